// File: verilog/la_pkg.sv
package la_pkg;

    typedef logic [31:0] la_addr_t;
    typedef logic [31:0] la_data_t;
    typedef logic [3:0]  la_strb_t;
    typedef logic [3:0]  axi_id_t;
    typedef logic [7:0]  axi_len_t;
    typedef logic [1:0]  axi_burst_t;   // 0 fixed, 1 incr, 2/3 rejected
    typedef logic [1:0]  axi_resp_t;
    typedef logic [5:0]  trig_op_t;     // [5:3] comparison, [2:0] value
    typedef logic [1:0]  global_mode_t;

    localparam axi_burst_t BURST_INCR  = 2'd1;
    localparam axi_resp_t  RESP_OKAY   = 2'b00;
    localparam axi_resp_t  RESP_SLVERR = 2'b10;

    localparam global_mode_t GLOBAL_AND  = 2'd0;
    localparam global_mode_t GLOBAL_OR   = 2'd1;
    localparam global_mode_t GLOBAL_NAND = 2'd2;
    localparam global_mode_t GLOBAL_NOR  = 2'd3;

    // anything other than != acts as ==
    localparam logic [2:0] CMP_EQ = 3'd0;
    localparam logic [2:0] CMP_NE = 3'd1;

    localparam logic [2:0] VAL_LOW    = 3'd0;
    localparam logic [2:0] VAL_HIGH   = 3'd1;
    localparam logic [2:0] VAL_ANY    = 3'd2;
    localparam logic [2:0] VAL_RISE   = 3'd3;
    localparam logic [2:0] VAL_FALL   = 3'd4;
    localparam logic [2:0] VAL_EDGE   = 3'd5;
    localparam logic [2:0] VAL_STABLE = 3'd6;

    localparam trig_op_t OP_RESET = {CMP_EQ, VAL_ANY};

    localparam la_addr_t ADDR_CTRL    = 32'h0000_0000;
    localparam la_addr_t ADDR_MODE    = 32'h0000_0001;
    localparam la_addr_t ADDR_OP_BASE = 32'h0000_0010;
    localparam la_addr_t PROT_LO      = 32'h0100_0000;
    localparam la_addr_t PROT_HI      = 32'h01FF_FFFF;
    localparam la_data_t RD_UNMAPPED  = 32'hFFFF_FFFF;

    typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_t;
    typedef enum logic {RD_IDLE, RD_DATA} rd_state_t;

endpackage

// File: verilog/reg_wr_if.sv
`timescale 1ns/100ps

// one accepted write beat per cycle
interface reg_wr_if import la_pkg::*; ();

    logic     wr_en;
    la_addr_t wr_addr;
    la_data_t wr_data;
    la_strb_t wr_strb;

    modport src (
        output wr_en, wr_addr, wr_data, wr_strb
    );

    modport dst (
        input wr_en, wr_addr, wr_data, wr_strb
    );

endinterface

// File: verilog/trig_cfg_if.sv
`timescale 1ns/100ps

interface trig_cfg_if import la_pkg::*; #(
    parameter int NUM_CHANNELS = 32
) ();

    logic                           capture_on;
    logic                           trig_force;
    global_mode_t                   global_mode;
    trig_op_t [NUM_CHANNELS-1:0]    ops;        // one operator per channel
    logic                           trig;

    modport cfg (
        output capture_on, trig_force, global_mode, ops,
        input  trig
    );

    modport eval (
        input  capture_on, trig_force, global_mode, ops,
        output trig
    );

endinterface

// File: verilog/axi_wr_channel.sv
`timescale 1ns/100ps

module axi_wr_channel import la_pkg::*; (
    input  logic       clk,
    input  logic       analyzer_rstn_sync,
    input  axi_id_t    wr_addr_id,
    input  la_addr_t   wr_addr,
    input  axi_burst_t wr_addr_burst,
    input  logic       wr_addr_valid,
    output logic       wr_addr_ready,
    input  la_data_t   wr_data,
    input  la_strb_t   wr_strb,
    input  logic       wr_data_last,
    input  logic       wr_data_valid,
    output logic       wr_data_ready,
    output axi_id_t    wr_resp_id,
    output axi_resp_t  wr_resp,
    output logic       wr_resp_valid,
    input  logic       wr_resp_ready,
    reg_wr_if.src      bus
);

    wr_state_t  state, state_nxt;
    axi_id_t    id_q;
    axi_burst_t burst_q;
    la_addr_t   beat_addr;
    logic       err_q;
    logic       addr_hs, beat_hs, beat_err;

    assign addr_hs = wr_addr_valid && wr_addr_ready;
    assign beat_hs = wr_data_valid && wr_data_ready;

    // bad burst type or a beat inside the protected window
    assign beat_err = burst_q[1] || ((beat_addr >= PROT_LO) && (beat_addr <= PROT_HI));

    always_comb begin
        state_nxt = state;
        case (state)
            WR_IDLE: if (addr_hs) state_nxt = WR_DATA;
            WR_DATA: if (beat_hs && wr_data_last) state_nxt = WR_RESP;
            WR_RESP: if (wr_resp_ready) state_nxt = WR_IDLE;
            default: state_nxt = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge analyzer_rstn_sync) begin
        if (!analyzer_rstn_sync) begin
            state <= WR_IDLE;
            err_q <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == WR_IDLE)
                err_q <= 1'b0;
            else if (beat_hs && beat_err)
                err_q <= 1'b1;          // sticky until the burst is done
        end
    end

    always_ff @(posedge clk) begin
        if (addr_hs) begin
            id_q      <= wr_addr_id;
            burst_q   <= wr_addr_burst;
            beat_addr <= wr_addr;
        end else if (beat_hs && (burst_q == BURST_INCR)) begin
            beat_addr <= beat_addr + 1'b1;
        end
    end

    assign wr_addr_ready = (state == WR_IDLE);
    assign wr_data_ready = (state == WR_DATA);
    assign wr_resp_valid = (state == WR_RESP);
    assign wr_resp_id    = id_q;
    assign wr_resp       = err_q ? RESP_SLVERR : RESP_OKAY;

    assign bus.wr_en   = beat_hs;
    assign bus.wr_addr = beat_addr;
    assign bus.wr_data = wr_data;
    assign bus.wr_strb = wr_strb;

    // response only follows the beat that carried last
    a_resp_after_last: assert property (@(posedge clk) disable iff (!analyzer_rstn_sync)
        $rose(wr_resp_valid) |-> $past(beat_hs && wr_data_last));

    a_addr_hold: assert property (@(posedge clk) disable iff (!analyzer_rstn_sync)
        (state == WR_DATA) && !wr_data_valid |=> $stable(bus.wr_addr));

endmodule

// File: verilog/axi_rd_channel.sv
`timescale 1ns/100ps

module axi_rd_channel import la_pkg::*; (
    input  logic       clk,
    input  logic       analyzer_rstn_sync,
    input  axi_id_t    rd_addr_id,
    input  la_addr_t   rd_req_addr,     // bus address of the burst
    input  axi_len_t   rd_addr_len,
    input  axi_burst_t rd_addr_burst,
    input  logic       rd_addr_valid,
    output logic       rd_addr_ready,
    output axi_id_t    rd_data_id,
    output axi_resp_t  rd_data_resp,
    output logic       rd_data_last,
    output logic       rd_data_valid,
    input  logic       rd_data_ready,
    output la_addr_t   rd_addr,         // beat address to the decode
    input  la_data_t   rd_word,
    output la_data_t   rd_data
);

    rd_state_t  state;
    axi_id_t    id_q;
    axi_len_t   len_q;
    axi_burst_t burst_q;
    axi_len_t   beat_cnt;
    logic       addr_hs, beat_hs;

    assign addr_hs = rd_addr_valid && rd_addr_ready;
    assign beat_hs = rd_data_valid && rd_data_ready;

    always_ff @(posedge clk or negedge analyzer_rstn_sync) begin
        if (!analyzer_rstn_sync) begin
            state    <= RD_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                RD_IDLE: begin
                    beat_cnt <= '0;
                    if (addr_hs) state <= RD_DATA;
                end
                RD_DATA: begin
                    if (beat_hs) beat_cnt <= beat_cnt + 1'b1;
                    if (beat_hs && rd_data_last) state <= RD_IDLE;
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (addr_hs) begin
            id_q    <= rd_addr_id;
            len_q   <= rd_addr_len;
            burst_q <= rd_addr_burst;
            rd_addr <= rd_req_addr;
        end else if (beat_hs && (burst_q == BURST_INCR)) begin
            rd_addr <= rd_addr + 1'b1;
        end
    end

    assign rd_addr_ready = (state == RD_IDLE);
    assign rd_data_valid = (state == RD_DATA);
    assign rd_data_last  = rd_data_valid && (beat_cnt == len_q);
    assign rd_data_id    = id_q;
    assign rd_data_resp  = (rd_data_valid && burst_q[1]) ? RESP_SLVERR : RESP_OKAY;
    assign rd_data       = rd_data_valid ? rd_word : '0;   // quiet bus when idle

    // a stalled beat keeps its address and last flag
    a_beat_hold: assert property (@(posedge clk) disable iff (!analyzer_rstn_sync)
        rd_data_valid && !rd_data_ready |=>
            rd_data_valid && $stable(rd_addr) && $stable(rd_data_last));

endmodule

// File: verilog/la_reg_bank.sv
`timescale 1ns/100ps

module la_reg_bank import la_pkg::*; #(
    parameter int NUM_CHANNELS = 32
) (
    input  logic     clk,
    input  logic     analyzer_rstn_sync,
    reg_wr_if.dst    bus,
    input  la_addr_t rd_addr,
    output la_data_t rd_word,
    trig_cfg_if.cfg  cfg
);

    localparam int IDX_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1;

    logic                        capture_on;
    logic                        trig_force;
    global_mode_t                mode_q;
    trig_op_t [NUM_CHANNELS-1:0] ops_q;
    la_addr_t                    wr_off, rd_off;

    // offset into the op block wraps high below the base
    assign wr_off = bus.wr_addr - ADDR_OP_BASE;
    assign rd_off = rd_addr - ADDR_OP_BASE;

    always_ff @(posedge clk or negedge analyzer_rstn_sync) begin
        if (!analyzer_rstn_sync) begin
            capture_on <= 1'b0;
            trig_force <= 1'b0;
            mode_q     <= GLOBAL_AND;
            ops_q      <= {NUM_CHANNELS{OP_RESET}};
        end else if (bus.wr_en) begin
            if (bus.wr_addr == ADDR_CTRL) begin
                if (bus.wr_strb[0]) capture_on <= bus.wr_data[0];
                if (bus.wr_strb[1]) trig_force <= bus.wr_data[8];
            end else if (bus.wr_addr == ADDR_MODE) begin
                if (bus.wr_strb[0]) mode_q <= bus.wr_data[1:0];
            end else if (wr_off < la_addr_t'(NUM_CHANNELS)) begin
                if (bus.wr_strb[0]) ops_q[wr_off[IDX_W-1:0]] <= bus.wr_data[5:0];
            end
        end else begin
            if (cfg.trig) capture_on <= 1'b0;   // armed once per trigger
            trig_force <= 1'b0;
        end
    end

    always_comb begin
        rd_word = RD_UNMAPPED;
        if (rd_addr == ADDR_CTRL)
            rd_word = {23'b0, trig_force, 7'b0, capture_on};   // busy/done read 0
        else if (rd_addr == ADDR_MODE)
            rd_word = {30'b0, mode_q};
        else if (rd_off < la_addr_t'(NUM_CHANNELS))
            rd_word = {26'b0, ops_q[rd_off[IDX_W-1:0]]};
    end

    assign cfg.capture_on  = capture_on;
    assign cfg.trig_force  = trig_force;
    assign cfg.global_mode = mode_q;
    assign cfg.ops         = ops_q;

    // a trigger without a competing write disarms capture
    a_auto_clear: assert property (@(posedge clk) disable iff (!analyzer_rstn_sync)
        cfg.trig && !bus.wr_en |=> !capture_on);

endmodule

// File: verilog/trigger_unit.sv
`timescale 1ns/100ps

module trigger_unit import la_pkg::*; #(
    parameter int NUM_CHANNELS = 32
) (
    input  logic        clk,
    input  logic        analyzer_rstn_sync,
    input  logic [31:0] digital_in,
    trig_cfg_if.eval    cfg
);

    logic [NUM_CHANNELS-1:0] prev_q;
    logic [31:0]             hit;

    function automatic logic op_match(trig_op_t op, logic now, logic prev);
        logic m;
        case (op[2:0])
            VAL_LOW:    m = !now;
            VAL_HIGH:   m = now;
            VAL_RISE:   m = !prev && now;
            VAL_FALL:   m = prev && !now;
            VAL_EDGE:   m = prev ^ now;
            VAL_STABLE: m = (prev == now);
            default:    m = 1'b1;           // any, and the unused code 7
        endcase
        return (op[5:3] == CMP_NE) ? !m : m;
    endfunction

    always_ff @(posedge clk or negedge analyzer_rstn_sync) begin
        if (!analyzer_rstn_sync)
            prev_q <= '0;
        else
            prev_q <= digital_in[NUM_CHANNELS-1:0];
    end

    for (genvar c = 0; c < 32; c++) begin : gen_ch
        if (c < NUM_CHANNELS) begin : gen_used
            assign hit[c] = op_match(cfg.ops[c], digital_in[c], prev_q[c]);
        end else begin : gen_unused
            assign hit[c] = 1'b1;   // neutral for and, forces or
        end
    end

    always_comb begin
        if (!cfg.capture_on)
            cfg.trig = 1'b0;
        else if (cfg.trig_force)
            cfg.trig = 1'b1;
        else begin
            case (cfg.global_mode)
                GLOBAL_AND:  cfg.trig = &hit;
                GLOBAL_OR:   cfg.trig = |hit;
                GLOBAL_NAND: cfg.trig = ~&hit;
                default:     cfg.trig = ~|hit;
            endcase
        end
    end

    // configuration must be defined once armed
    a_cfg_known: assert property (@(posedge clk) disable iff (!analyzer_rstn_sync)
        cfg.capture_on |-> !$isunknown({cfg.trig_force, cfg.global_mode, cfg.ops}));

endmodule

// File: verilog/logic_analyzer_ctrl.sv
`timescale 1ns/100ps

module logic_analyzer_ctrl import la_pkg::*; #(
    parameter int NUM_CHANNELS = 32
) (
    input  logic        clk,
    input  logic        analyzer_rstn_sync,
    input  logic [31:0] digital_in,
    input  axi_id_t     wr_addr_id,
    input  la_addr_t    wr_addr,
    input  axi_burst_t  wr_addr_burst,
    input  logic        wr_addr_valid,
    output logic        wr_addr_ready,
    input  la_data_t    wr_data,
    input  la_strb_t    wr_strb,
    input  logic        wr_data_last,
    input  logic        wr_data_valid,
    output logic        wr_data_ready,
    output axi_id_t     wr_resp_id,
    output axi_resp_t   wr_resp,
    output logic        wr_resp_valid,
    input  logic        wr_resp_ready,
    input  axi_id_t     rd_addr_id,
    input  la_addr_t    rd_addr,
    input  axi_len_t    rd_addr_len,
    input  axi_burst_t  rd_addr_burst,
    input  logic        rd_addr_valid,
    output logic        rd_addr_ready,
    output axi_id_t     rd_data_id,
    output la_data_t    rd_data,
    output axi_resp_t   rd_data_resp,
    output logic        rd_data_last,
    output logic        rd_data_valid,
    input  logic        rd_data_ready,
    output logic        trig
);

    la_addr_t rd_beat_addr;
    la_data_t rd_word;

    reg_wr_if wr_bus ();
    trig_cfg_if #(.NUM_CHANNELS(NUM_CHANNELS)) cfg_bus ();

    axi_wr_channel i_axi_wr_channel (
        .clk, .analyzer_rstn_sync,
        .wr_addr_id, .wr_addr, .wr_addr_burst, .wr_addr_valid, .wr_addr_ready,
        .wr_data, .wr_strb, .wr_data_last, .wr_data_valid, .wr_data_ready,
        .wr_resp_id, .wr_resp, .wr_resp_valid, .wr_resp_ready,
        .bus (wr_bus.src)
    );

    axi_rd_channel i_axi_rd_channel (
        .clk, .analyzer_rstn_sync,
        .rd_addr_id, .rd_req_addr (rd_addr), .rd_addr_len, .rd_addr_burst,
        .rd_addr_valid, .rd_addr_ready,
        .rd_data_id, .rd_data_resp, .rd_data_last, .rd_data_valid, .rd_data_ready,
        .rd_addr (rd_beat_addr),
        .rd_word (rd_word),
        .rd_data (rd_data)
    );

    la_reg_bank #(.NUM_CHANNELS(NUM_CHANNELS)) i_la_reg_bank (
        .clk, .analyzer_rstn_sync,
        .bus     (wr_bus.dst),
        .rd_addr (rd_beat_addr),
        .rd_word (rd_word),
        .cfg     (cfg_bus.cfg)
    );

    trigger_unit #(.NUM_CHANNELS(NUM_CHANNELS)) i_trigger_unit (
        .clk, .analyzer_rstn_sync,
        .digital_in,
        .cfg (cfg_bus.eval)
    );

    assign trig = cfg_bus.trig;

endmodule

// File: verif/tb_logic_analyzer.sv
`timescale 1ns/100ps

module tb_logic_analyzer import la_pkg::*; ();

    localparam axi_burst_t BURST_FIXED = 2'd0;

    logic        clk, analyzer_rstn_sync;
    logic [31:0] digital_in;
    axi_id_t     wr_addr_id, wr_resp_id, rd_addr_id, rd_data_id;
    la_addr_t    wr_addr, rd_addr;
    axi_burst_t  wr_addr_burst, rd_addr_burst;
    axi_len_t    rd_addr_len;
    la_data_t    wr_data, rd_data;
    la_strb_t    wr_strb;
    axi_resp_t   wr_resp, rd_data_resp;
    logic        wr_addr_valid, wr_addr_ready, wr_data_last, wr_data_valid, wr_data_ready;
    logic        wr_resp_valid, wr_resp_ready, rd_addr_valid, rd_addr_ready;
    logic        rd_data_last, rd_data_valid, rd_data_ready, trig;

    // reference model of the register image and the sample history
    logic         m_cap, m_force;
    global_mode_t m_mode;
    trig_op_t     m_ops [32];
    logic [31:0]  m_prev;
    la_addr_t     m_waddr;
    axi_burst_t   m_wburst;

    // what the next rising edge will do as seen at the falling edge
    logic         p_en, p_hs, p_ahs, p_trig;
    la_addr_t     p_aaddr;
    axi_burst_t   p_aburst;
    la_data_t     p_data;
    la_strb_t     p_strb;
    logic [31:0]  p_din;

    logic [31:0]  rnd_state, din_state;
    int           trig_cnt;
    la_data_t     last_rd;
    la_data_t     wq_data [$];
    la_strb_t     wq_strb [$];

    logic_analyzer_ctrl #(.NUM_CHANNELS(32)) i_logic_analyzer_ctrl (.*);

    function automatic logic [31:0] lcg(inout logic [31:0] s);
        s = s * 32'd1664525 + 32'd1013904223;
        return s;
    endfunction

    function automatic logic [31:0] rnd32(inout logic [31:0] s);
        logic [31:0] hi, lo;
        hi = lcg(s);
        lo = lcg(s);
        return {hi[31:16], lo[31:16]};   // low lcg bits cycle too fast
    endfunction

    function automatic int unsigned pick(input int unsigned n);
        logic [31:0] v;
        v = lcg(rnd_state);
        return v[31:16] % n;
    endfunction

    function automatic logic model_trig(input logic [31:0] din);
        logic [31:0] hit;
        logic        m;
        trig_op_t    op;
        for (int c = 0; c < 32; c++) begin
            op = m_ops[c];
            case (op[2:0])
                VAL_LOW:    m = (din[c] == 1'b0);
                VAL_HIGH:   m = (din[c] == 1'b1);
                VAL_RISE:   m = (m_prev[c] == 1'b0) && (din[c] == 1'b1);
                VAL_FALL:   m = (m_prev[c] == 1'b1) && (din[c] == 1'b0);
                VAL_EDGE:   m = (m_prev[c] != din[c]);
                VAL_STABLE: m = (m_prev[c] == din[c]);
                default:    m = 1'b1;
            endcase
            hit[c] = (op[5:3] == CMP_NE) ? !m : m;
        end
        if (!m_cap)
            return 1'b0;
        if (m_force)
            return 1'b1;
        case (m_mode)
            GLOBAL_AND:  return (hit == 32'hFFFF_FFFF);
            GLOBAL_OR:   return (hit != 32'h0);
            GLOBAL_NAND: return (hit != 32'hFFFF_FFFF);
            default:     return (hit == 32'h0);
        endcase
    endfunction

    function automatic la_data_t model_read(input la_addr_t a);
        if (a == ADDR_CTRL)
            return {23'd0, m_force, 7'd0, m_cap};
        if (a == ADDR_MODE)
            return {30'd0, m_mode};
        if (a >= ADDR_OP_BASE && a < ADDR_OP_BASE + 32)
            return {26'd0, m_ops[a - ADDR_OP_BASE]};
        return RD_UNMAPPED;
    endfunction

    function automatic void apply_write(input la_addr_t a, input la_data_t d, input la_strb_t s);
        if (a == ADDR_CTRL) begin
            if (s[0]) m_cap = d[0];
            if (s[1]) m_force = d[8];
        end else if (a == ADDR_MODE) begin
            if (s[0]) m_mode = d[1:0];
        end else if (a >= ADDR_OP_BASE && a < ADDR_OP_BASE + 32) begin
            if (s[0]) m_ops[a - ADDR_OP_BASE] = d[5:0];
        end
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic stop_on_timeout(input string what);
        abort_run({"timed out waiting for ", what});
    endtask

    task automatic check_data(input la_data_t got, input la_data_t exp, input string what);
        if (got !== exp)
            abort_run($sformatf("Fail at %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_resp(input axi_resp_t got, input axi_resp_t exp, input string what);
        if (got !== exp)
            abort_run($sformatf("Fail at %0t: %s is %b, expected %b", $time, what, got, exp));
    endtask

    task automatic check_id(input axi_id_t got, input axi_id_t exp, input string what);
        if (got !== exp)
            abort_run($sformatf("Fail at %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_last(input logic got, input logic exp, input string what);
        if (got !== exp)
            abort_run($sformatf("Fail at %0t: %s is %b, expected %b", $time, what, got, exp));
    endtask

    task automatic check_trig(input logic got, input logic exp, input string what);
        if (got !== exp)
            abort_run($sformatf("Fail at %0t: %s is %b, expected %b", $time, what, got, exp));
    endtask

    task automatic push_beat(input la_data_t d, input la_strb_t s);
        wq_data.push_back(d);
        wq_strb.push_back(s);
    endtask

    // sends the queued beats as one burst and checks the response
    task automatic write_burst(input la_addr_t addr, input axi_burst_t burst);
        la_addr_t  a;
        logic      err, got;
        axi_id_t   id, rid;
        axi_resp_t resp;
        int        t, n;
        a = addr;
        err = burst[1];
        n = wq_data.size();
        for (int i = 0; i < n; i++) begin
            if (a >= PROT_LO && a <= PROT_HI) err = 1'b1;
            if (burst == BURST_INCR) a++;
        end
        @(posedge clk);
        #1;
        id = 4'(pick(16));
        wr_addr = addr;
        wr_addr_burst = burst;
        wr_addr_id = id;
        wr_addr_valid = 1'b1;
        t = 0;
        do begin
            @(negedge clk);
            t++;
            if (t > 50) stop_on_timeout("write address ready");
        end while (!wr_addr_ready);
        @(posedge clk);
        #1;
        wr_addr_valid = 1'b0;
        for (int i = 0; i < n; i++) begin
            wr_data = wq_data[i];
            wr_strb = wq_strb[i];
            wr_data_last = (i == n - 1);
            wr_data_valid = 1'b1;
            t = 0;
            do begin
                @(negedge clk);
                t++;
                if (t > 50) stop_on_timeout("write data ready");
            end while (!wr_data_ready);
            @(posedge clk);
            #1;
        end
        wr_data_valid = 1'b0;
        wr_data_last = 1'b0;
        t = 0;
        do begin
            wr_resp_ready = 1'(pick(2));     // random back-pressure
            @(negedge clk);
            t++;
            if (t > 200) stop_on_timeout("write response");
            got = wr_resp_valid && wr_resp_ready;
            resp = wr_resp;
            rid = wr_resp_id;
            @(posedge clk);
            #1;
        end while (!got);
        wr_resp_ready = 1'b0;
        check_resp(resp, err ? RESP_SLVERR : RESP_OKAY, "write response");
        check_id(rid, id, "write response id");
        wq_data = {};
        wq_strb = {};
    endtask

    task automatic write_one(input la_addr_t addr, input la_data_t d, input la_strb_t s);
        push_beat(d, s);
        write_burst(addr, BURST_INCR);
    endtask

    task automatic read_burst(input la_addr_t addr, input axi_burst_t burst, input axi_len_t len);
        la_addr_t  a;
        axi_id_t   id;
        axi_resp_t exp_resp;
        int        beat, t;
        a = addr;
        beat = 0;
        exp_resp = burst[1] ? RESP_SLVERR : RESP_OKAY;
        @(posedge clk);
        #1;
        id = 4'(pick(16));
        rd_addr = addr;
        rd_addr_burst = burst;
        rd_addr_len = len;
        rd_addr_id = id;
        rd_addr_valid = 1'b1;
        t = 0;
        do begin
            @(negedge clk);
            t++;
            if (t > 50) stop_on_timeout("read address ready");
        end while (!rd_addr_ready);
        @(posedge clk);
        #1;
        rd_addr_valid = 1'b0;
        t = 0;
        while (beat <= len) begin
            rd_data_ready = (pick(4) != 0);     // stall one cycle in four
            @(negedge clk);
            if (rd_data_valid && rd_data_ready) begin
                last_rd = rd_data;
                check_data(rd_data, model_read(a), "read data");
                check_resp(rd_data_resp, exp_resp, "read response");
                check_id(rd_data_id, id, "read id");
                check_last(rd_data_last, beat == len, "read last");
                beat++;
                if (burst == BURST_INCR) a++;
            end
            t++;
            if (t > 2000) stop_on_timeout("read data");
            @(posedge clk);
            #1;
        end
        rd_data_ready = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        din_state = 32'd96539;
        forever begin
            @(posedge clk);
            #1;
            digital_in = rnd32(din_state);
        end
    end

    always @(negedge clk) begin
        p_en = analyzer_rstn_sync;
        p_trig = model_trig(digital_in);
        if (analyzer_rstn_sync) begin
            check_trig(trig, p_trig, "trig");
            if (trig) trig_cnt++;
        end
        p_ahs = wr_addr_valid && wr_addr_ready;
        p_aaddr = wr_addr;
        p_aburst = wr_addr_burst;
        p_hs = wr_data_valid && wr_data_ready;
        p_data = wr_data;
        p_strb = wr_strb;
        p_din = digital_in;
    end

    always @(posedge clk) begin
        if (p_en) begin
            if (p_ahs) begin
                m_waddr = p_aaddr;
                m_wburst = p_aburst;
            end
            if (p_hs) begin
                apply_write(m_waddr, p_data, p_strb);
                if (m_wburst == BURST_INCR) m_waddr++;
            end else begin
                if (p_trig) m_cap = 1'b0;   // disarm on trigger
                m_force = 1'b0;
            end
            m_prev = p_din;
        end
    end

    initial begin
        int           sel, n, sh, start, t;
        la_addr_t     base;
        global_mode_t mode;
        trig_op_t     op;
        logic [2:0]   v;
        analyzer_rstn_sync = 1'b0;
        digital_in = '0;
        {wr_addr_id, wr_addr, wr_addr_burst, wr_addr_valid} = '0;
        {wr_data, wr_strb, wr_data_last, wr_data_valid, wr_resp_ready} = '0;
        {rd_addr_id, rd_addr, rd_addr_len, rd_addr_burst, rd_addr_valid, rd_data_ready} = '0;
        rnd_state = 32'd96539;
        {m_cap, m_force, m_mode, m_prev, m_waddr, m_wburst} = '0;
        foreach (m_ops[i]) m_ops[i] = OP_RESET;
        {p_en, p_hs, p_ahs, p_trig, p_aaddr, p_aburst, p_data, p_strb, p_din} = '0;
        trig_cnt = 0;
        repeat (8) @(posedge clk);
        #1;
        analyzer_rstn_sync = 1'b1;

        @(negedge clk);
        check_last(wr_addr_ready, 1'b1, "wr_addr_ready after reset");
        check_last(rd_addr_ready, 1'b1, "rd_addr_ready after reset");
        check_last(wr_data_ready, 1'b0, "wr_data_ready after reset");
        check_last(wr_resp_valid, 1'b0, "wr_resp_valid after reset");
        check_last(rd_data_valid, 1'b0, "rd_data_valid after reset");
        check_last(rd_data_last, 1'b0, "rd_data_last after reset");
        read_burst(ADDR_CTRL, BURST_FIXED, 0);
        check_data(last_rd, 32'h0, "control after reset");
        read_burst(ADDR_MODE, BURST_FIXED, 0);
        check_data(last_rd, 32'h0, "mode after reset");
        read_burst(ADDR_OP_BASE + pick(32), BURST_INCR, 0);
        check_data(last_rd, 32'h2, "operator after reset");

        // random register traffic
        repeat (40) begin
            sel = pick(3);
            base = (sel == 0) ? ADDR_CTRL : (sel == 1) ? ADDR_MODE : ADDR_OP_BASE + pick(32);
            n = 1 + pick(4);
            repeat (n) push_beat(rnd32(rnd_state), 4'(pick(16)));
            write_burst(base, 2'(pick(2)));
            read_burst(base, 2'(pick(2)), 8'(pick(6)));
        end

        // protected window, error bursts, unmapped reads
        push_beat(rnd32(rnd_state), 4'hF);
        push_beat(rnd32(rnd_state), 4'hF);
        write_burst(PROT_LO - 1, BURST_INCR);     // second beat lands in the window
        write_one(PROT_LO + pick(256), rnd32(rnd_state), 4'hF);
        read_burst(ADDR_CTRL, BURST_INCR, 1);
        write_one(ADDR_OP_BASE + 32, rnd32(rnd_state), 4'hF);
        push_beat(rnd32(rnd_state), 4'(pick(16)));
        write_burst(ADDR_MODE, 2'd2);
        read_burst(ADDR_MODE, 2'd3, 2);
        read_burst(32'h100 + pick(64), BURST_INCR, 3);
        check_data(last_rd, RD_UNMAPPED, "unmapped read");

        // a few random channels per round with the rest neutral
        write_one(ADDR_CTRL, 32'h0, 4'h3);
        repeat (8) begin
            mode = 2'(pick(4));
            sh = pick(11);
            for (int c = 0; c < 32; c++) begin
                if ((c % 11) == sh) begin
                    v = 3'(pick(6));
                    if (v >= VAL_ANY) v = v + 3'd1;
                    op = {3'(pick(8)), v};
                end else if (mode == GLOBAL_AND || mode == GLOBAL_NAND) begin
                    op = OP_RESET;
                end else begin
                    op = {CMP_NE, VAL_ANY};
                end
                push_beat({26'd0, op}, 4'h1);
            end
            write_burst(ADDR_OP_BASE, BURST_INCR);
            write_one(ADDR_MODE, {30'd0, mode}, 4'h1);
            start = trig_cnt;
            write_one(ADDR_CTRL, 32'h1, 4'h1);
            t = 0;
            while (trig_cnt == start) begin
                @(posedge clk);
                t++;
                if (t > 3000) stop_on_timeout("trigger to fire");
            end
            read_burst(ADDR_CTRL, BURST_FIXED, 0);
            check_last(last_rd[0], 1'b0, "capture on after trigger");
        end

        // channel 0 never hits so only force can fire
        write_one(ADDR_OP_BASE, {26'd0, CMP_NE, VAL_ANY}, 4'h1);
        write_one(ADDR_MODE, {30'd0, GLOBAL_AND}, 4'h1);
        start = trig_cnt;
        write_one(ADDR_CTRL, 32'h101, 4'h3);
        repeat (4) @(posedge clk);
        check_data(la_data_t'(trig_cnt - start), 32'd1, "trigger cycles after force");

        // would fire at once if capture were on
        write_one(ADDR_OP_BASE, {26'd0, OP_RESET}, 4'h1);
        write_one(ADDR_MODE, {30'd0, GLOBAL_OR}, 4'h1);
        write_one(ADDR_CTRL, 32'h0, 4'h3);
        repeat (20) begin
            @(negedge clk);
            check_trig(trig, 1'b0, "trig while disarmed");
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

// File: all.f
verilog/la_pkg.sv
verilog/reg_wr_if.sv
verilog/trig_cfg_if.sv
verilog/axi_wr_channel.sv
verilog/axi_rd_channel.sv
verilog/la_reg_bank.sv
verilog/trigger_unit.sv
verilog/logic_analyzer_ctrl.sv
verif/tb_logic_analyzer.sv

// File: Bender.yml
package:
  name: logic_analyzer_ctrl

sources:
  - verilog/la_pkg.sv
  - verilog/reg_wr_if.sv
  - verilog/trig_cfg_if.sv
  - verilog/axi_wr_channel.sv
  - verilog/axi_rd_channel.sv
  - verilog/la_reg_bank.sv
  - verilog/trigger_unit.sv
  - verilog/logic_analyzer_ctrl.sv
  - target: test
    files:
      - verif/tb_logic_analyzer.sv
